//--- hdl/dac_serializer.sv
// Quad DAC serializer; sends one 24-bit write-and-update frame per channel on each update strobe
`default_nettype none

module dac_serializer #(
    parameter int NUM_CHAN    = 4,
    parameter int DAC_CLK_DIV = 2             // sysclk cycles per SCLK half period
) (
    input  wire                                       sysclk,
    input  wire                                       rst_n,
    input  wire                                       dac_update,
    input  wire [NUM_CHAN*qla_pkg::CUR_CMD_W-1:0]     cur_cmd_all,
    output logic                                      dac_busy,
    output logic                                      dac_sclk,
    output logic                                      dac_mosi,
    output logic                                      dac_csel
);

    localparam int                   DIV_W     = $clog2(DAC_CLK_DIV) + 1;
    localparam logic [DIV_W-1:0]     DIV_LAST  = DIV_W'(DAC_CLK_DIV - 1);
    localparam logic [DIV_W-1:0]     GAP_LAST  = DIV_W'(1);     // Two cycles CS high
    localparam logic [4:0]           LAST_BIT  = 5'(qla_pkg::DAC_FRAME_BITS - 1);
    localparam logic [3:0]           CHAN_LAST = 4'(NUM_CHAN - 1);

    qla_pkg::dac_state_e                         state;
    logic [DIV_W-1:0]                            div_cnt;
    logic [4:0]                                  bit_cnt;
    logic [3:0]                                  chan_cnt;   // 0-based, also DAC address
    logic [qla_pkg::DAC_FRAME_BITS-1:0]          frame_sr;
    logic [NUM_CHAN*qla_pkg::CUR_CMD_W-1:0]      snap;       // Remaining channels
    logic                                        accept;
    logic                                        load_next;

    assign accept    = (state == qla_pkg::DAC_IDLE) && dac_update;
    assign load_next = (state == qla_pkg::DAC_GAP) && (div_cnt == GAP_LAST) &&
                       (chan_cnt != CHAN_LAST);

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state    <= qla_pkg::DAC_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            chan_cnt <= '0;
            frame_sr <= '0;
            dac_sclk <= 1'b0;
            dac_csel <= 1'b1;
        end else begin
            case (state)
                qla_pkg::DAC_IDLE: begin
                    if (accept) begin
                        state    <= qla_pkg::DAC_SHIFT;
                        dac_csel <= 1'b0;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        chan_cnt <= '0;
                        frame_sr <= {qla_pkg::DAC_CMD_WRITE_UPDATE, 4'd0,
                                     cur_cmd_all[qla_pkg::CUR_CMD_W-1:0]};
                    end
                end
                qla_pkg::DAC_SHIFT: begin
                    if (div_cnt != DIV_LAST) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        if (!dac_sclk) begin
                            dac_sclk <= 1'b1;           // DAC samples here
                        end else begin
                            dac_sclk <= 1'b0;
                            if (bit_cnt == LAST_BIT) begin
                                dac_csel <= 1'b1;       // End of frame
                                frame_sr <= '0;
                                state    <= qla_pkg::DAC_GAP;
                            end else begin
                                bit_cnt  <= bit_cnt + 1'b1;
                                frame_sr <= {frame_sr[qla_pkg::DAC_FRAME_BITS-2:0], 1'b0};
                            end
                        end
                    end
                end
                qla_pkg::DAC_GAP: begin
                    if (div_cnt != GAP_LAST) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else if (load_next) begin
                        state    <= qla_pkg::DAC_SHIFT;
                        dac_csel <= 1'b0;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        chan_cnt <= chan_cnt + 4'd1;
                        frame_sr <= {qla_pkg::DAC_CMD_WRITE_UPDATE, chan_cnt + 4'd1,
                                     snap[qla_pkg::CUR_CMD_W-1:0]};
                    end else begin
                        div_cnt <= '0;
                        state   <= qla_pkg::DAC_IDLE;   // Burst done
                    end
                end
                default: begin
                    state <= qla_pkg::DAC_IDLE;
                end
            endcase
        end
    end

    // Snapshot at accept, shifted down one channel per frame
    always_ff @(posedge sysclk) begin
        if (accept) begin
            snap <= cur_cmd_all >> qla_pkg::CUR_CMD_W;
        end else if (load_next) begin
            snap <= snap >> qla_pkg::CUR_CMD_W;
        end
    end

    assign dac_mosi = frame_sr[qla_pkg::DAC_FRAME_BITS-1];     // MSB first
    assign dac_busy = (state != qla_pkg::DAC_IDLE);

endmodule

`default_nettype wire

//--- hdl/motor_channel.sv
// One motor axis; holds commanded current and amp enable, latches amp faults, drives disable pin
`default_nettype none

module motor_channel #(
    parameter int CHAN = 1                       // Axis number, 1-based
) (
    input  wire                   sysclk,
    input  wire                   rst_n,
    input  wire                   amp_fault_n,   // Low when amp reports fault
    input  wire qla_pkg::chan_write_t chan_wr,
    output qla_pkg::chan_status_t status,
    output logic                  amp_disable_pin
);

    localparam logic [3:0] CHAN_ID = 4'(CHAN);

    logic                          wr_hit;
    logic                          cfg_wr;
    logic [qla_pkg::CUR_CMD_W-1:0] cur_cmd;
    logic                          amp_enable;
    logic                          fault_latched;

    // Decoder broadcasts; pick out our own writes
    assign wr_hit = chan_wr.wen && (chan_wr.chan == CHAN_ID);
    assign cfg_wr = wr_hit && (chan_wr.offset == qla_pkg::OFF_MOTOR_CONFIG);

    // ----------------------------------------
    // Command and config registers
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd    <= '0;
            amp_enable <= 1'b0;
        end else if (wr_hit) begin
            case (chan_wr.offset)
                qla_pkg::OFF_DAC_CTRL: begin
                    cur_cmd <= chan_wr.data[qla_pkg::CUR_CMD_W-1:0];
                end
                qla_pkg::OFF_MOTOR_CONFIG: begin
                    amp_enable <= chan_wr.data[0];
                end
                default: begin
                    // Status is read only
                end
            endcase
        end
    end

    // ----------------------------------------
    // Fault latch
    // ----------------------------------------
    // Only counts while the amp is on, since a disabled amp pulls fault low
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            fault_latched <= 1'b0;
        end else if (cfg_wr && chan_wr.data[0]) begin
            fault_latched <= 1'b0;             // Re-enable clears
        end else if (amp_enable && !amp_fault_n) begin
            fault_latched <= 1'b1;
        end
    end

    // Active high disable; off unless enabled and fault free
    assign amp_disable_pin = !(amp_enable && !fault_latched);

    assign status = '{
        cur_cmd:       cur_cmd,
        amp_enable:    amp_enable,
        fault_latched: fault_latched,
        amp_fault_n:   amp_fault_n,
        amp_disable:   amp_disable_pin
    };

endmodule

`default_nettype wire

//--- hdl/qla_motor_ctrl.sv
// Top level of the four-axis motor command path; connects host bus, channels, DAC and read mux
`default_nettype none

module qla_motor_ctrl #(
    parameter int NUM_CHAN    = 4,
    parameter int DAC_CLK_DIV = 2
) (
    input  wire                sysclk,
    input  wire                rst_n,

    // Host register bus
    input  wire [15:0]         reg_waddr,
    input  wire [31:0]         reg_wdata,
    input  wire                reg_wen,
    input  wire                blk_wen,        // High on last quadlet of block write
    input  wire [15:0]         reg_raddr,
    output wire [31:0]         reg_rdata,

    // Amplifier pins, index is axis number
    input  wire [NUM_CHAN:1]   amp_fault_n,
    output wire [NUM_CHAN:1]   amp_disable_pin,

    // Quad DAC
    output wire                dac_sclk,
    output wire                dac_mosi,
    output wire                dac_csel
);

    wire qla_pkg::chan_write_t  chan_wr;
    wire qla_pkg::chan_status_t chan_status [1:NUM_CHAN];
    wire [NUM_CHAN*qla_pkg::CUR_CMD_W-1:0] cur_cmd_all;    // Axis 1 in low bits
    wire                        dac_update;
    wire                        dac_busy;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    reg_write_decode #(
        .NUM_CHAN(NUM_CHAN)
    ) write_decode_i (
        .sysclk(sysclk),
        .rst_n(rst_n),
        .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata),
        .reg_wen(reg_wen),
        .blk_wen(blk_wen),
        .dac_busy(dac_busy),
        .chan_wr(chan_wr),
        .dac_update(dac_update)
    );

    // ----------------------------------------
    // Motor channels
    // ----------------------------------------
    genvar k;
    generate
        for (k = 1; k <= NUM_CHAN; k = k + 1) begin : mchan_loop
            motor_channel #(
                .CHAN(k)
            ) motor_i (
                .sysclk(sysclk),
                .rst_n(rst_n),
                .amp_fault_n(amp_fault_n[k]),
                .chan_wr(chan_wr),
                .status(chan_status[k]),
                .amp_disable_pin(amp_disable_pin[k])
            );

            // Pack for the serializer
            assign cur_cmd_all[(k-1)*qla_pkg::CUR_CMD_W +: qla_pkg::CUR_CMD_W] =
                chan_status[k].cur_cmd;
        end
    endgenerate

    // ----------------------------------------
    // DAC and readback
    // ----------------------------------------
    dac_serializer #(
        .NUM_CHAN(NUM_CHAN),
        .DAC_CLK_DIV(DAC_CLK_DIV)
    ) dac_i (
        .sysclk(sysclk),
        .rst_n(rst_n),
        .dac_update(dac_update),
        .cur_cmd_all(cur_cmd_all),
        .dac_busy(dac_busy),
        .dac_sclk(dac_sclk),
        .dac_mosi(dac_mosi),
        .dac_csel(dac_csel)
    );

    reg_read_mux #(
        .NUM_CHAN(NUM_CHAN)
    ) read_mux_i (
        .sysclk(sysclk),
        .rst_n(rst_n),
        .reg_raddr(reg_raddr),
        .chan_status(chan_status),
        .reg_rdata(reg_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/qla_pkg.sv
// Shared types and constants for the motor channel command path, referenced by scoped names
`default_nettype none

package qla_pkg;

    // ----------------------------------------
    // Widths and DAC constants
    // ----------------------------------------
    localparam int CUR_CMD_W      = 16;           // Commanded current width
    localparam int DAC_FRAME_BITS = 24;           // Quad DAC serial word

    // Write input register and update output
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'b0011;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    // Address space in bits 15:12
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'h0                          // Board and channel registers
    } addr_space_e;

    // Per-channel register offset in bits 3:0
    typedef enum logic [3:0] {
        OFF_DAC_CTRL     = 4'h1,                  // Commanded current
        OFF_MOTOR_CONFIG = 4'hA,                  // Amplifier enable
        OFF_MOTOR_STATUS = 4'hC                   // Command plus fault flags
    } reg_offset_e;

    // ----------------------------------------
    // Bundles between blocks
    // ----------------------------------------
    // One registered host write, broadcast to every channel
    typedef struct packed {
        logic        wen;                         // Single-cycle strobe
        logic [3:0]  chan;                        // Target channel, 1-based
        reg_offset_e offset;
        logic [31:0] data;
    } chan_write_t;

    // Channel state seen by the DAC path and the read mux
    typedef struct packed {
        logic [CUR_CMD_W-1:0] cur_cmd;
        logic                 amp_enable;
        logic                 fault_latched;
        logic                 amp_fault_n;        // Raw pin, low on fault
        logic                 amp_disable;        // Same as the pin
    } chan_status_t;

    // DAC serializer FSM
    typedef enum logic [1:0] {
        DAC_IDLE,                                 // CS high, waiting for update
        DAC_SHIFT,                                // Clocking one frame out
        DAC_GAP                                   // CS high between frames
    } dac_state_e;

endpackage

`default_nettype wire

//--- hdl/reg_read_mux.sv
// Registered read mux returning per-channel command, status and config words to the host bus
`default_nettype none

module reg_read_mux #(
    parameter int NUM_CHAN = 4
) (
    input  wire                        sysclk,
    input  wire                        rst_n,
    input  wire [15:0]                 reg_raddr,
    input  wire qla_pkg::chan_status_t chan_status [1:NUM_CHAN],
    output logic [31:0]                reg_rdata
);

    localparam logic [3:0] MAX_CHAN = 4'(NUM_CHAN);

    logic                  rd_hit;
    logic [3:0]            rchan;
    qla_pkg::reg_offset_e  roff;
    qla_pkg::chan_status_t sel;
    logic [31:0]           rdata_next;

    assign rchan  = reg_raddr[7:4];
    assign roff   = qla_pkg::reg_offset_e'(reg_raddr[3:0]);
    assign rd_hit = (reg_raddr[15:12] == qla_pkg::ADDR_MAIN) &&
                    (rchan != 4'd0) && (rchan <= MAX_CHAN);

    // ----------------------------------------
    // Word select
    // ----------------------------------------
    always_comb begin
        sel        = '0;
        rdata_next = '0;                                   // Unmapped reads 0
        if (rd_hit) begin
            sel = chan_status[rchan];
            case (roff)
                qla_pkg::OFF_DAC_CTRL:     rdata_next = {16'd0, sel.cur_cmd};
                qla_pkg::OFF_MOTOR_STATUS: rdata_next = {sel.cur_cmd, 12'd0,
                                                         sel.amp_disable, sel.amp_fault_n,
                                                         sel.fault_latched, sel.amp_enable};
                qla_pkg::OFF_MOTOR_CONFIG: rdata_next = {31'd0, sel.amp_enable};
                default:                   rdata_next = '0;
            endcase
        end
    end

    // One cycle read latency
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rdata_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_write_decode.sv
// Host write decoder; registers channel writes and issues DAC update strobes when the DAC is idle
`default_nettype none

module reg_write_decode #(
    parameter int NUM_CHAN = 4
) (
    input  wire                  sysclk,
    input  wire                  rst_n,
    input  wire [15:0]           reg_waddr,
    input  wire [31:0]           reg_wdata,
    input  wire                  reg_wen,
    input  wire                  blk_wen,
    input  wire                  dac_busy,
    output qla_pkg::chan_write_t chan_wr,
    output logic                 dac_update
);

    localparam logic [3:0] MAX_CHAN = 4'(NUM_CHAN);

    logic                 wr_hit;     // Write lands on a real channel
    logic                 dac_wr;     // ...and on the current command
    logic                 dac_fire;
    logic                 dac_req;    // Pending update, merges repeats

    logic                 wen_q;
    logic [3:0]           chan_q;
    qla_pkg::reg_offset_e offset_q;
    logic [31:0]          data_q;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    // Channel 0 is the board register block, not ours
    assign wr_hit = reg_wen && (reg_waddr[15:12] == qla_pkg::ADDR_MAIN) &&
                    (reg_waddr[7:4] != 4'd0) && (reg_waddr[7:4] <= MAX_CHAN);
    assign dac_wr = wr_hit && (reg_waddr[3:0] == qla_pkg::OFF_DAC_CTRL);

    // Hold off while a strobe is still in flight to the serializer
    assign dac_fire = dac_req && !dac_busy && !dac_update;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wen_q      <= 1'b0;
            dac_req    <= 1'b0;
            dac_update <= 1'b0;
        end else begin
            wen_q      <= wr_hit;              // One-cycle strobe
            dac_update <= dac_fire;
            if (dac_wr) begin
                dac_req <= blk_wen;            // Last quadlet of block write
            end else if (dac_fire) begin
                dac_req <= 1'b0;
            end
        end
    end

    // Payload only qualified by wen_q
    always_ff @(posedge sysclk) begin
        chan_q   <= reg_waddr[7:4];
        offset_q <= qla_pkg::reg_offset_e'(reg_waddr[3:0]);
        data_q   <= reg_wdata;
    end

    assign chan_wr = '{wen: wen_q, chan: chan_q, offset: offset_q, data: data_q};

endmodule

`default_nettype wire

//--- qla_motor_ctrl.f
hdl/qla_pkg.sv
hdl/reg_write_decode.sv
hdl/motor_channel.sv
hdl/dac_serializer.sv
hdl/reg_read_mux.sv
hdl/qla_motor_ctrl.sv
testbench/qla_motor_ctrl_assert.sv
testbench/tb_qla_motor_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the motor command path testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_qla_motor_ctrl \
    -f qla_motor_ctrl.f \
    -o sim_tb

# A failing run exits nonzero, the log is checked below
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "Simulation FAILED: run ended without a result"
    exit 1
fi
echo "Simulation PASSED"

//--- testbench/qla_motor_ctrl_assert.sv
// Concurrent checks on the DAC pins and amplifier disable, bound into the motor command top level
`default_nettype none

module qla_motor_ctrl_assert #(
    parameter int NUM_CHAN = 4
) (
    input wire                sysclk,
    input wire                rst_n,
    input wire                dac_sclk,
    input wire                dac_csel,
    input wire [NUM_CHAN:1]   amp_fault_n,
    input wire [NUM_CHAN:1]   amp_disable_pin
);

    // ----------------------------------------
    // DAC bus
    // ----------------------------------------
    sclk_idle: assert property (@(posedge sysclk) disable iff (!rst_n) dac_csel |-> !dac_sclk)
        else $error("DAC clock high while chip select is high");

    csel_reset: assert property (@(posedge sysclk) !rst_n |=> dac_csel)
        else $error("DAC chip select not high after a reset cycle");

    // Fault on a running amp must disable it next cycle
    genvar k;
    generate
        for (k = 1; k <= NUM_CHAN; k = k + 1) begin : fault_chk
            fault_disable: assert property (@(posedge sysclk) disable iff (!rst_n)
                (!amp_disable_pin[k] && !amp_fault_n[k]) |=> amp_disable_pin[k])
                else $error("Amplifier %0d still enabled after a fault", k);
        end
    endgenerate

endmodule

bind qla_motor_ctrl qla_motor_ctrl_assert #(
    .NUM_CHAN(NUM_CHAN)
) qla_motor_ctrl_assert_i (
    .sysclk(sysclk),
    .rst_n(rst_n),
    .dac_sclk(dac_sclk),
    .dac_csel(dac_csel),
    .amp_fault_n(amp_fault_n),
    .amp_disable_pin(amp_disable_pin)
);

`default_nettype wire

//--- testbench/tb_qla_motor_ctrl.sv
// Testbench for the motor command path; drives host writes and checks readback, DAC frames and faults
`default_nettype none

module tb_qla_motor_ctrl;

    localparam int NUM_CHAN    = 4;
    localparam int DAC_CLK_DIV = 2;
    localparam int TIMEOUT     = 4000;   // About twice the sum of all test phases
    localparam int QUIET_WAIT  = 150;    // Longer than one whole DAC frame

    logic        sysclk;
    logic        rst_n;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic        blk_wen;
    logic [15:0] reg_raddr;
    wire  [31:0] reg_rdata;
    logic [NUM_CHAN:1] amp_fault_n;
    wire  [NUM_CHAN:1] amp_disable_pin;
    wire         dac_sclk;
    wire         dac_mosi;
    wire         dac_csel;

    int seed        = 57772;
    int cycle_cnt   = 0;
    int rx_bits     = 0;
    int frame_starts = 0;                // Chip select falls seen

    // Reference model of each axis
    logic [15:0] m_cmd [1:NUM_CHAN];
    logic        m_en  [1:NUM_CHAN];
    logic        m_flt [1:NUM_CHAN];

    logic [23:0] exp_q [$];              // Frames still expected, in order
    logic [23:0] rx_q [$];               // Frames captured off the pins
    logic [23:0] rx_frame;

    qla_motor_ctrl #(
        .NUM_CHAN(NUM_CHAN),
        .DAC_CLK_DIV(DAC_CLK_DIV)
    ) qla_motor_ctrl_i (
        .sysclk(sysclk),
        .rst_n(rst_n),
        .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata),
        .reg_wen(reg_wen),
        .blk_wen(blk_wen),
        .reg_raddr(reg_raddr),
        .reg_rdata(reg_rdata),
        .amp_fault_n(amp_fault_n),
        .amp_disable_pin(amp_disable_pin),
        .dac_sclk(dac_sclk),
        .dac_mosi(dac_mosi),
        .dac_csel(dac_csel)
    );

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    // ----------------------------------------
    // Reporting and model helpers
    // ----------------------------------------
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT));
        end
    end

    function automatic logic [15:0] chan_addr(input int ch, input logic [3:0] off);
        chan_addr = {qla_pkg::ADDR_MAIN, 4'h0, 4'(ch), off};
    endfunction

    // Expected read word for any address
    function automatic logic [31:0] exp_read(input logic [15:0] addr);
        int   ch;
        logic dis;
        ch       = int'(addr[7:4]);
        exp_read = 32'd0;                                  // Unmapped
        if (addr[15:12] == qla_pkg::ADDR_MAIN && ch >= 1 && ch <= NUM_CHAN) begin
            dis = !(m_en[ch] && !m_flt[ch]);
            case (addr[3:0])
                qla_pkg::OFF_DAC_CTRL:     exp_read = {16'd0, m_cmd[ch]};
                qla_pkg::OFF_MOTOR_STATUS: exp_read = {m_cmd[ch], 12'd0, dis,
                                                       amp_fault_n[ch], m_flt[ch], m_en[ch]};
                qla_pkg::OFF_MOTOR_CONFIG: exp_read = {31'd0, m_en[ch]};
                default:                   exp_read = 32'd0;
            endcase
        end
    endfunction

    // Command nibble, DAC address, then current
    function automatic logic [23:0] exp_frame(input int ch);
        exp_frame = {qla_pkg::DAC_CMD_WRITE_UPDATE, 4'(ch - 1), m_cmd[ch]};
    endfunction

    function automatic void update_model(input logic [15:0] addr, input logic [31:0] data);
        int ch;
        ch = int'(addr[7:4]);
        if (addr[15:12] == qla_pkg::ADDR_MAIN && ch >= 1 && ch <= NUM_CHAN) begin
            if (addr[3:0] == qla_pkg::OFF_DAC_CTRL) begin
                m_cmd[ch] = data[15:0];
            end else if (addr[3:0] == qla_pkg::OFF_MOTOR_CONFIG) begin
                m_en[ch] = data[0];
                if (data[0]) begin
                    m_flt[ch] = 1'b0;                      // Re-enable clears latch
                end
            end
        end
    endfunction

    function automatic void push_burst();
        int c;
        for (c = 1; c <= NUM_CHAN; c++) begin
            exp_q.push_back(exp_frame(c));
        end
    endfunction

    // ----------------------------------------
    // Bus tasks
    // ----------------------------------------
    task automatic host_write(input logic [15:0] addr, input logic [31:0] data, input logic blk);
        @(negedge sysclk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        blk_wen   = blk;
        @(negedge sysclk);
        reg_wen = 1'b0;
        blk_wen = 1'b0;
        update_model(addr, data);
        repeat (2) @(negedge sysclk);                      // Channel state settles at N+2
    endtask

    task automatic check_read(input logic [15:0] addr);
        logic [31:0] exp;
        @(negedge sysclk);
        reg_raddr = addr;
        repeat (2) @(negedge sysclk);
        exp = exp_read(addr);
        assert (reg_rdata === exp) else
            stop_on_error($sformatf("Mismatch at %0t: read 0x%04h got 0x%08h expected 0x%08h",
                                    $time, addr, reg_rdata, exp));
    endtask

    task automatic check_all_regs();
        int c;
        for (c = 1; c <= NUM_CHAN; c++) begin
            check_read(chan_addr(c, qla_pkg::OFF_DAC_CTRL));
            check_read(chan_addr(c, qla_pkg::OFF_MOTOR_STATUS));
            check_read(chan_addr(c, qla_pkg::OFF_MOTOR_CONFIG));
        end
    endtask

    task automatic check_pins();
        logic [NUM_CHAN:1] exp;
        int c;
        for (c = 1; c <= NUM_CHAN; c++) begin
            exp[c] = !(m_en[c] && !m_flt[c]);
        end
        assert (amp_disable_pin === exp) else
            stop_on_error($sformatf("Mismatch at %0t: amp_disable_pin got %b expected %b",
                                    $time, amp_disable_pin, exp));
    endtask

    task automatic wait_burst_done();
        while (exp_q.size() != 0) @(negedge sysclk);
        while (qla_motor_ctrl_i.dac_busy) @(negedge sysclk);   // Busy falls at burst end
    endtask

    // ----------------------------------------
    // DAC monitor and frame compare
    // ----------------------------------------
    always @(negedge dac_csel) begin
        rx_bits      = 0;
        frame_starts = frame_starts + 1;
    end

    always @(posedge dac_sclk) begin
        if (!dac_csel) begin
            rx_frame = {rx_frame[22:0], dac_mosi};          // MSB first
            rx_bits  = rx_bits + 1;
            if (rx_bits == 24) begin
                rx_q.push_back(rx_frame);
                rx_bits = 0;
            end
        end
    end

    always @(negedge sysclk) begin
        logic [23:0] got;
        logic [23:0] exp;
        if (rx_q.size() != 0) begin
            got = rx_q.pop_front();
            assert (exp_q.size() != 0) else
                stop_on_error($sformatf("Unexpected DAC frame 0x%06h at %0t", got, $time));
            exp = exp_q.pop_front();
            assert (got === exp) else
                stop_on_error($sformatf("Mismatch at %0t: DAC frame got 0x%06h expected 0x%06h",
                                        $time, got, exp));
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rnd;
        int          ch;
        int          k;
        int          starts;
        rst_n       = 1'b0;
        reg_waddr   = '0;
        reg_wdata   = '0;
        reg_wen     = 1'b0;
        blk_wen     = 1'b0;
        reg_raddr   = '0;
        amp_fault_n = '1;                                  // No amp faults
        for (ch = 1; ch <= NUM_CHAN; ch++) begin
            m_cmd[ch] = '0;
            m_en[ch]  = 1'b0;
            m_flt[ch] = 1'b0;
        end
        repeat (10) @(negedge sysclk);
        rst_n = 1'b1;

        // Reset state
        assert (dac_csel === 1'b1) else stop_on_error("DAC chip select is not high after reset");
        check_pins();
        check_all_regs();

        // Random writes and readback
        for (k = 0; k < 12; k++) begin
            rnd = $random(seed);
            ch  = 1 + int'(rnd[7:0]) % NUM_CHAN;
            host_write(chan_addr(ch, qla_pkg::OFF_DAC_CTRL), $random(seed), 1'b0);
            host_write(chan_addr(ch, qla_pkg::OFF_MOTOR_CONFIG), $random(seed), 1'b0);
        end
        check_all_regs();
        check_pins();
        // Channel 0, channel 5 and space 1 are ignored, block flag too
        host_write({qla_pkg::ADDR_MAIN, 4'h0, 4'h0, 4'(qla_pkg::OFF_DAC_CTRL)}, $random(seed), 1'b1);
        host_write({qla_pkg::ADDR_MAIN, 4'h0, 4'h5, 4'(qla_pkg::OFF_DAC_CTRL)}, $random(seed), 1'b1);
        // Flips axis 1 enable if the space were decoded wrongly
        host_write({4'h1, 4'h0, 4'h1, 4'(qla_pkg::OFF_MOTOR_CONFIG)}, {31'd0, !m_en[1]}, 1'b0);
        check_all_regs();
        check_pins();

        // DAC update from a block write
        host_write(chan_addr(3, qla_pkg::OFF_DAC_CTRL), $random(seed), 1'b1);
        push_burst();
        wait_burst_done();
        starts = frame_starts;
        host_write(chan_addr(2, qla_pkg::OFF_DAC_CTRL), $random(seed), 1'b0);
        repeat (QUIET_WAIT) @(negedge sysclk);
        assert (frame_starts == starts) else stop_on_error("DAC frame sent without a block write");

        // Merged requests while a burst runs
        starts = frame_starts;
        host_write(chan_addr(1, qla_pkg::OFF_DAC_CTRL), $random(seed), 1'b1);
        push_burst();
        while (dac_csel) @(negedge sysclk);
        for (k = 0; k < 3; k++) begin
            rnd = $random(seed);
            ch  = 1 + int'(rnd[7:0]) % NUM_CHAN;
            host_write(chan_addr(ch, qla_pkg::OFF_DAC_CTRL), $random(seed), 1'b1);
        end
        push_burst();                                      // Latest values only
        wait_burst_done();
        repeat (QUIET_WAIT) @(negedge sysclk);
        assert (frame_starts == starts + 2 * NUM_CHAN) else
            stop_on_error("Merged block writes did not give exactly one extra DAC burst");
        check_all_regs();

        // Amplifier fault on an enabled channel
        host_write(chan_addr(2, qla_pkg::OFF_MOTOR_CONFIG), 32'h1, 1'b0);
        host_write(chan_addr(3, qla_pkg::OFF_MOTOR_CONFIG), 32'h0, 1'b0);
        check_pins();
        @(negedge sysclk);
        amp_fault_n[2] = 1'b0;
        amp_fault_n[3] = 1'b0;                             // Disabled axis ignores it
        @(negedge sysclk);
        amp_fault_n[2] = 1'b1;
        amp_fault_n[3] = 1'b1;
        m_flt[2] = 1'b1;
        @(negedge sysclk);
        check_pins();
        check_read(chan_addr(2, qla_pkg::OFF_MOTOR_STATUS));
        check_read(chan_addr(3, qla_pkg::OFF_MOTOR_STATUS));
        host_write(chan_addr(2, qla_pkg::OFF_MOTOR_CONFIG), 32'h1, 1'b0);
        check_pins();
        check_read(chan_addr(2, qla_pkg::OFF_MOTOR_STATUS));

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
